/* vlog.f */
verilog/mailbox_pkg.sv
verilog/ctrl_port.sv
verilog/reader_select.sv
verilog/mailbox_fifo.sv
verilog/ownership_ctrl.sv
verilog/notify_out.sv
verilog/shared_mailbox.sv
tb/tb_clock.sv
tb/shared_mailbox_tb.sv

/* Bender.yml */
package:
  name: shared_mailbox

sources:
  - verilog/mailbox_pkg.sv
  - verilog/ctrl_port.sv
  - verilog/reader_select.sv
  - verilog/mailbox_fifo.sv
  - verilog/ownership_ctrl.sv
  - verilog/notify_out.sv
  - verilog/shared_mailbox.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/shared_mailbox_tb.sv

/* tb/shared_mailbox_tb.sv */
// Shared mailbox testbench
// Runs a table of control, push, pop and status rows against the DUT
// and checks the read data against a model queue of pushed words.
`timescale 1ns/1ns

module shared_mailbox_tb;

	import mailbox_pkg::*;

	localparam int HS_BOUND = 64;
	localparam int STALL_CYCLES = 8;
	localparam int BUSY_BOUND = 3 * TICK_CYCLES + 4;

	typedef enum logic [2:0] {OP_CWR, OP_CRD, OP_PUSH, OP_POP, OP_WAIT, OP_IDLE} op_t;

	// port is a reader index for pops and a request mask for idle rows
	typedef struct packed {
		op_t                    op;
		logic [NUM_READERS-1:0] port;
		logic [WORD_W-1:0]      data;
		logic [WORD_W-1:0]      exp;
	} row_t;

	logic                   clk;
	logic                   resetn;
	logic                   ctrl_req;
	logic                   ctrl_wr;
	logic [WORD_W-1:0]      ctrl_wdata;
	logic                   ctrl_ack;
	logic [WORD_W-1:0]      ctrl_rdata;
	logic                   wr_req;
	logic [WORD_W-1:0]      wr_data;
	logic                   wr_ack;
	logic [NUM_READERS-1:0] rd_req;
	logic [NUM_READERS-1:0] rd_ack;
	logic [WORD_W-1:0]      rd_data;
	logic [BUSY_W-1:0]      busy;
	logic [NUM_READERS-1:0] data_irq;
	logic                   ctrl_irq;

	row_t              rows[$];
	int                num_rows;
	logic [WORD_W-1:0] model_q[$];
	logic [OWNER_W-1:0] exp_owner;
	logic [31:0]       lcg_state;
	logic              push_pending;
	logic [WORD_W-1:0] pending_word;

	tb_clock tb_clock_inst (
		.clk    (clk),
		.resetn (resetn)
	);

	shared_mailbox shared_mailbox_inst (
		.clk        (clk),
		.resetn     (resetn),
		.ctrl_req   (ctrl_req),
		.ctrl_wr    (ctrl_wr),
		.ctrl_wdata (ctrl_wdata),
		.ctrl_ack   (ctrl_ack),
		.ctrl_rdata (ctrl_rdata),
		.wr_req     (wr_req),
		.wr_data    (wr_data),
		.wr_ack     (wr_ack),
		.rd_req     (rd_req),
		.rd_ack     (rd_ack),
		.rd_data    (rd_data),
		.busy       (busy),
		.data_irq   (data_irq),
		.ctrl_irq   (ctrl_irq)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic word_compare(input string name, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	task automatic busy_compare(input string name, input logic [BUSY_W-1:0] got,
			input logic [BUSY_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	task automatic irq_compare(input string name, input logic [NUM_READERS-1:0] got,
			input logic [NUM_READERS-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Owner's bit while words are queued, nothing for owners without a port
	function automatic logic [NUM_READERS-1:0] expect_irq();
		logic [NUM_READERS-1:0] v;
		v = '0;
		if (exp_owner < NUM_READERS && model_q.size() != 0)
			v[exp_owner] = 1'b1;
		return v;
	endfunction

	// 0 is the control ack, 1 the writer ack, 2 and up the reader acks
	function automatic logic ack_of(input int sel);
		case (sel)
			0: return ctrl_ack;
			1: return wr_ack;
			default: return rd_ack[sel-2];
		endcase
	endfunction

	task automatic wait_ack(input int sel, input logic level, input string what);
		int n;
		n = 0;
		while (ack_of(sel) !== level)
		begin
			if (n == HS_BOUND)
				abort_run($sformatf("the %s handshake did not complete in time", what));
			@(negedge clk);
			n++;
		end
	endtask

	task automatic ctrl_access(input logic wr, input logic [WORD_W-1:0] wdata,
			output logic [WORD_W-1:0] rdata);
		@(posedge clk);
		ctrl_req <= 1'b1;
		ctrl_wr <= wr;
		ctrl_wdata <= wdata;
		@(negedge clk);
		wait_ack(0, 1'b1, "control");
		rdata = ctrl_rdata;
		@(posedge clk);
		ctrl_req <= 1'b0;
		@(negedge clk);
		wait_ack(0, 1'b0, "control");
	endtask

	task automatic finish_push();
		wait_ack(1, 1'b1, "writer");
		@(posedge clk);
		wr_req <= 1'b0;
		@(negedge clk);
		wait_ack(1, 1'b0, "writer");
		model_q.push_back(pending_word);
		push_pending = 1'b0;
	endtask

	task automatic push_word(input logic blocked);
		lcg_state = lcg_next(lcg_state);
		pending_word = lcg_state;
		@(posedge clk);
		wr_req <= 1'b1;
		wr_data <= pending_word;
		@(negedge clk);
		if (blocked)
		begin
			// Left pending, the next pop frees the slot
			repeat (STALL_CYCLES)
			begin
				if (wr_ack !== 1'b0)
					abort_run("the writer was acked while the FIFO was full");
				@(negedge clk);
			end
			push_pending = 1'b1;
		end
		else
		begin
			finish_push();
			irq_compare("data_irq", data_irq, expect_irq());
		end
	endtask

	task automatic pop_word(input int port);
		logic [WORD_W-1:0] want;
		@(posedge clk);
		rd_req <= NUM_READERS'(1) << port;
		@(negedge clk);
		wait_ack(2 + port, 1'b1, "reader");
		if (model_q.size() == 0)
			abort_run("a reader was acked with no word in the mailbox");
		want = model_q.pop_front();
		word_compare("rd_data", rd_data, want);
		@(posedge clk);
		rd_req <= '0;
		@(negedge clk);
		wait_ack(2 + port, 1'b0, "reader");
		if (push_pending)
			finish_push();
		@(negedge clk);
		irq_compare("data_irq", data_irq, expect_irq());
	endtask

	task automatic idle_ports(input logic [NUM_READERS-1:0] mask);
		@(posedge clk);
		rd_req <= mask;
		@(negedge clk);
		repeat (STALL_CYCLES)
		begin
			if (rd_ack !== '0)
				abort_run("a reader without ownership was acked");
			@(negedge clk);
		end
		@(posedge clk);
		rd_req <= '0;
		@(negedge clk);
	endtask

	// Flags word: busy in [7:0], data_irq in [10:8], ctrl_irq in bit 12
	task automatic wait_busy(input logic [WORD_W-1:0] exp);
		int n;
		n = 0;
		while (busy !== exp[BUSY_W-1:0] && n < BUSY_BOUND)
		begin
			@(negedge clk);
			n++;
		end
		busy_compare("busy", busy, exp[BUSY_W-1:0]);
		irq_compare("data_irq", data_irq, exp[8 +: NUM_READERS]);
		irq_compare("ctrl_irq", NUM_READERS'(ctrl_irq), NUM_READERS'(exp[12]));
		// Revocation flushed the FIFO and freed the mailbox
		if (exp[12])
		begin
			model_q.delete();
			exp_owner = NO_OWNER;
		end
	endtask

	task automatic run_row(input row_t r);
		logic [WORD_W-1:0] got;
		case (r.op)
			OP_CWR:
			begin
				ctrl_access(1'b1, r.data, got);
				exp_owner = r.data[OWNER_MSB:OWNER_LSB];
			end
			OP_CRD:
			begin
				ctrl_access(1'b0, '0, got);
				word_compare("ctrl_rdata", got, r.exp);
			end
			OP_PUSH: push_word(r.exp[0]);
			OP_POP: pop_word(r.port);
			OP_WAIT: wait_busy(r.exp);
			default: idle_ports(r.port);
		endcase
	endtask

	function automatic void add_row(input op_t op, input logic [NUM_READERS-1:0] port,
			input logic [WORD_W-1:0] data, input logic [WORD_W-1:0] exp);
		rows.push_back(row_t'({op, port, data, exp}));
	endfunction

	// State words are owner, time quota, zero, read limit from the top byte down
	function automatic void build_table();
		add_row(OP_WAIT, 3'd0, '0, 32'h0000_0000);
		add_row(OP_CRD, 3'd0, '0, RESET_STATE);
		// Owner 1, no quotas
		add_row(OP_CWR, 3'd0, 32'h0100_0000, '0);
		add_row(OP_WAIT, 3'd0, '0, 32'h0000_0002);
		add_row(OP_PUSH, 3'd0, '0, 32'd0);
		add_row(OP_PUSH, 3'd0, '0, 32'd0);
		add_row(OP_IDLE, 3'b101, '0, '0);
		add_row(OP_POP, 3'd1, '0, '0);
		add_row(OP_POP, 3'd1, '0, '0);
		// Fifth word waits for a free slot
		for (int i = 0; i < FIFO_DEPTH; i++)
			add_row(OP_PUSH, 3'd0, '0, 32'd0);
		add_row(OP_PUSH, 3'd0, '0, 32'd1);
		for (int i = 0; i <= FIFO_DEPTH; i++)
			add_row(OP_POP, 3'd1, '0, '0);
		// Owner 2 with a read limit of 3
		add_row(OP_CWR, 3'd0, 32'h0200_0003, '0);
		add_row(OP_WAIT, 3'd0, '0, 32'h0000_0004);
		for (int i = 0; i < FIFO_DEPTH; i++)
			add_row(OP_PUSH, 3'd0, '0, 32'd0);
		add_row(OP_POP, 3'd2, '0, '0);
		add_row(OP_PUSH, 3'd0, '0, 32'd0);
		add_row(OP_POP, 3'd2, '0, '0);
		add_row(OP_POP, 3'd2, '0, '0);
		add_row(OP_WAIT, 3'd0, '0, 32'h0000_1000);
		add_row(OP_CRD, 3'd0, '0, RESET_STATE);
		add_row(OP_CWR, 3'd0, RESET_STATE, '0);
		add_row(OP_WAIT, 3'd0, '0, 32'h0000_0000);
		// Owner 0 with a time quota of 2 ticks
		add_row(OP_CWR, 3'd0, 32'h0002_0000, '0);
		add_row(OP_WAIT, 3'd0, '0, 32'h0000_0001);
		add_row(OP_WAIT, 3'd0, '0, 32'h0000_1000);
		// Owner 5 has no reader port
		add_row(OP_CWR, 3'd0, 32'h0500_0000, '0);
		add_row(OP_WAIT, 3'd0, '0, 32'h0000_0020);
		add_row(OP_PUSH, 3'd0, '0, 32'd0);
		add_row(OP_IDLE, 3'b111, '0, '0);
	endfunction

	initial
	begin
		ctrl_req = 1'b0;
		ctrl_wr = 1'b0;
		ctrl_wdata = '0;
		wr_req = 1'b0;
		wr_data = '0;
		rd_req = '0;
		lcg_state = 32'h1805;
		exp_owner = NO_OWNER;
		push_pending = 1'b0;
		pending_word = '0;
		num_rows = 0;
		build_table();
		num_rows = rows.size();
		wait (resetn === 1'b1);
		@(negedge clk);
		foreach (rows[i])
			run_row(rows[i]);
		$display("all tests passed");
		$finish;
	end

	// Each row gets a FIFO's worth of cycles plus four timer periods
	initial
	begin
		wait (num_rows > 0);
		repeat ((num_rows + 2) * (FIFO_DEPTH + 4 * TICK_CYCLES)) @(posedge clk);
		abort_run("the watchdog expired before the table finished");
	end

endmodule

/* tb/tb_clock.sv */
// Testbench clock and reset
// 4 ns clock, active-low reset held for the first two cycles
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic resetn
);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		resetn = 1'b0;
		repeat (2) @(posedge clk);
		resetn <= 1'b1;
	end

endmodule

/* verilog/shared_mailbox.sv */
// Shared mailbox top level
// One writer, three competing readers and one control port around a
// word FIFO whose ownership is bounded by a time quota and a read limit.
`timescale 1ns/1ns

module shared_mailbox (
	input  logic                                clk,
	input  logic                                resetn,
	input  logic                                ctrl_req,
	input  logic                                ctrl_wr,
	input  logic [mailbox_pkg::WORD_W-1:0]      ctrl_wdata,
	output logic                                ctrl_ack,
	output logic [mailbox_pkg::WORD_W-1:0]      ctrl_rdata,
	input  logic                                wr_req,
	input  logic [mailbox_pkg::WORD_W-1:0]      wr_data,
	output logic                                wr_ack,
	input  logic [mailbox_pkg::NUM_READERS-1:0] rd_req,
	output logic [mailbox_pkg::NUM_READERS-1:0] rd_ack,
	output logic [mailbox_pkg::WORD_W-1:0]      rd_data,
	output logic [mailbox_pkg::BUSY_W-1:0]      busy,
	output logic [mailbox_pkg::NUM_READERS-1:0] data_irq,
	output logic                                ctrl_irq
);

	import mailbox_pkg::*;

	logic               state_wr;
	logic [WORD_W-1:0]  state_wdata;
	logic [WORD_W-1:0]  state_word;
	logic               pop_req;
	logic               pop_ack;
	logic [WORD_W-1:0]  pop_data;
	logic               read_done;
	logic [OWNER_W-1:0] owner;
	logic               flush;
	logic               revoke;
	logic               empty;

	// Input side
	ctrl_port ctrl_port_inst (
		.clk         (clk),
		.resetn      (resetn),
		.ctrl_req    (ctrl_req),
		.ctrl_wr     (ctrl_wr),
		.ctrl_wdata  (ctrl_wdata),
		.ctrl_ack    (ctrl_ack),
		.ctrl_rdata  (ctrl_rdata),
		.state_wr    (state_wr),
		.state_wdata (state_wdata),
		.state_word  (state_word)
	);

	mailbox_fifo mailbox_fifo_inst (
		.clk      (clk),
		.resetn   (resetn),
		.wr_req   (wr_req),
		.wr_data  (wr_data),
		.wr_ack   (wr_ack),
		.pop_req  (pop_req),
		.pop_ack  (pop_ack),
		.pop_data (pop_data),
		.flush    (flush),
		.empty    (empty)
	);

	// Ownership and reader routing
	ownership_ctrl ownership_ctrl_inst (
		.clk         (clk),
		.resetn      (resetn),
		.state_wr    (state_wr),
		.state_wdata (state_wdata),
		.state_word  (state_word),
		.read_done   (read_done),
		.owner       (owner),
		.flush       (flush),
		.revoke      (revoke)
	);

	reader_select reader_select_inst (
		.clk       (clk),
		.resetn    (resetn),
		.rd_req    (rd_req),
		.rd_ack    (rd_ack),
		.rd_data   (rd_data),
		.owner     (owner),
		.pop_req   (pop_req),
		.pop_ack   (pop_ack),
		.pop_data  (pop_data),
		.read_done (read_done)
	);

	// Output side
	notify_out notify_out_inst (
		.clk      (clk),
		.resetn   (resetn),
		.owner    (owner),
		.empty    (empty),
		.revoke   (revoke),
		.state_wr (state_wr),
		.busy     (busy),
		.data_irq (data_irq),
		.ctrl_irq (ctrl_irq)
	);

endmodule

/* verilog/notify_out.sv */
// Mailbox status outputs
// Registered busy flags, per-reader data interrupts and the sticky
// control interrupt raised on revocation.
`timescale 1ns/1ns

module notify_out (
	input  logic                                clk,
	input  logic                                resetn,
	input  logic [mailbox_pkg::OWNER_W-1:0]     owner,
	input  logic                                empty,
	input  logic                                revoke,
	input  logic                                state_wr,
	output logic [mailbox_pkg::BUSY_W-1:0]      busy,
	output logic [mailbox_pkg::NUM_READERS-1:0] data_irq,
	output logic                                ctrl_irq
);

	import mailbox_pkg::*;

	// One-hot owner, all zero for NO_OWNER and other large ids
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			busy <= '0;
			data_irq <= '0;
		end
		else
		begin
			for (int i = 0; i < BUSY_W; i++)
				busy[i] <= (owner == i);
			for (int i = 0; i < NUM_READERS; i++)
				data_irq[i] <= (owner == i) && !empty;
		end
	end

	// Stays set until the next control write
	always_ff @(posedge clk)
	begin
		if (!resetn)
			ctrl_irq <= 1'b0;
		else if (revoke)
			ctrl_irq <= 1'b1;
		else if (state_wr)
			ctrl_irq <= 1'b0;
	end

endmodule

/* verilog/ownership_ctrl.sv */
// Mailbox ownership control
// Holds the state word, runs the tick timer, counts down the time quota
// and read limit, and revokes ownership when an armed count runs out.
`timescale 1ns/1ns

module ownership_ctrl (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic                            state_wr,
	input  logic [mailbox_pkg::WORD_W-1:0]  state_wdata,
	output logic [mailbox_pkg::WORD_W-1:0]  state_word,
	input  logic                            read_done,
	output logic [mailbox_pkg::OWNER_W-1:0] owner,
	output logic                            flush,
	output logic                            revoke
);

	import mailbox_pkg::*;

	logic [TICK_W-1:0]                tick_cnt;
	logic                             tick;
	logic                             has_owner;
	logic [TQUOTA_MSB-TQUOTA_LSB:0]   tquota;
	logic [RLIMIT_MSB-RLIMIT_LSB:0]   rlimit;
	logic                             t_hit;
	logic                             r_hit;
	logic                             expire;

	assign owner = state_word[OWNER_MSB:OWNER_LSB];
	assign tquota = state_word[TQUOTA_MSB:TQUOTA_LSB];
	assign rlimit = state_word[RLIMIT_MSB:RLIMIT_LSB];
	assign has_owner = (owner != NO_OWNER);
	assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

	// A count that has just reached zero, acted on one edge later
	assign expire = t_hit || r_hit;

	// Free-running timer, one tick per period
	always_ff @(posedge clk)
	begin
		if (!resetn || tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state_word <= RESET_STATE;
			t_hit <= 1'b0;
			r_hit <= 1'b0;
		end
		else if (state_wr)
		begin
			// A fresh write re-arms both counts
			state_word <= state_wdata;
			t_hit <= 1'b0;
			r_hit <= 1'b0;
		end
		else if (expire)
		begin
			state_word <= RESET_STATE;
			t_hit <= 1'b0;
			r_hit <= 1'b0;
		end
		else if (has_owner)
		begin
			// Zero in a field means unlimited, so only nonzero counts move
			if (tick && tquota != '0)
			begin
				state_word[TQUOTA_MSB:TQUOTA_LSB] <= tquota - 1'b1;
				t_hit <= (tquota == 'd1);
			end
			if (read_done && rlimit != '0)
			begin
				state_word[RLIMIT_MSB:RLIMIT_LSB] <= rlimit - 1'b1;
				r_hit <= (rlimit == 'd1);
			end
		end
	end

	// Pulses on the edge where the owner drops to none
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			flush <= 1'b0;
			revoke <= 1'b0;
		end
		else
		begin
			flush <= expire && !state_wr;
			revoke <= expire && !state_wr;
		end
	end

endmodule

/* verilog/mailbox_fifo.sv */
// Mailbox word FIFO
// Small circular buffer with four-phase push and pop responders.
// Push ack waits for room, pop ack waits for data, flush empties it.
`timescale 1ns/1ns

module mailbox_fifo (
	input  logic                           clk,
	input  logic                           resetn,
	input  logic                           wr_req,
	input  logic [mailbox_pkg::WORD_W-1:0] wr_data,
	output logic                           wr_ack,
	input  logic                           pop_req,
	output logic                           pop_ack,
	output logic [mailbox_pkg::WORD_W-1:0] pop_data,
	input  logic                           flush,
	output logic                           empty
);

	import mailbox_pkg::*;

	logic [WORD_W-1:0]  mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;
	logic               live;
	logic               do_push;
	logic               pop_start;
	logic               do_pop;

	assign empty = (count == '0);
	assign full = (count == (FIFO_AW+1)'(FIFO_DEPTH));

	// Word is stored on the edge that raises wr_ack
	assign do_push = wr_req && !wr_ack && !full;
	assign pop_start = pop_req && !pop_ack && !empty && !flush;

	// Head word leaves when pop ack falls, unless a flush already took it
	assign do_pop = pop_ack && !pop_req && live;
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (!resetn || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + do_push - do_pop;
		end
	end

	// Push and pop responders
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			wr_ack <= 1'b0;
			pop_ack <= 1'b0;
			live <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ack <= 1'b1;
			else if (wr_ack && !wr_req)
				wr_ack <= 1'b0;
			if (pop_start)
				pop_ack <= 1'b1;
			else if (pop_ack && !pop_req)
				pop_ack <= 1'b0;
			if (flush)
				live <= 1'b0;
			else if (pop_start)
				live <= 1'b1;
		end
	end

	// Writer holds req and data steady while it waits for room
	assert property (@(posedge clk) disable iff (!resetn)
		wr_req && !wr_ack |=> wr_req && $stable(wr_data));

endmodule

/* verilog/reader_select.sv */
// Reader port selector
// Connects only the owner's reader handshake to the FIFO pop side.
// The port that got an ack keeps it until the handshake closes.
`timescale 1ns/1ns

module reader_select (
	input  logic                                clk,
	input  logic                                resetn,
	input  logic [mailbox_pkg::NUM_READERS-1:0] rd_req,
	output logic [mailbox_pkg::NUM_READERS-1:0] rd_ack,
	output logic [mailbox_pkg::WORD_W-1:0]      rd_data,
	input  logic [mailbox_pkg::OWNER_W-1:0]     owner,
	output logic                                pop_req,
	input  logic                                pop_ack,
	input  logic [mailbox_pkg::WORD_W-1:0]      pop_data,
	output logic                                read_done
);

	import mailbox_pkg::*;

	logic [NUM_READERS-1:0] owner_sel;
	logic [NUM_READERS-1:0] hs_sel;
	logic [NUM_READERS-1:0] route_sel;

	// Owner ids without a reader port select nothing
	always_comb
	begin
		for (int i = 0; i < NUM_READERS; i++)
			owner_sel[i] = (owner == i);
	end

	// Follows the owner until the FIFO acks, then holds that port
	always_ff @(posedge clk)
	begin
		if (!resetn)
			hs_sel <= '0;
		else if (!pop_ack)
			hs_sel <= owner_sel;
	end

	// A requester that lost ownership before its ack just keeps waiting
	assign route_sel = pop_ack ? hs_sel : owner_sel;
	assign pop_req = |(rd_req & route_sel);
	assign rd_ack = pop_ack ? hs_sel : '0;

	// Shared read bus, meaningful only on the acked port
	assign rd_data = pop_data;

	// Same condition as the FIFO uses to drop ack and pop
	always_ff @(posedge clk)
	begin
		if (!resetn)
			read_done <= 1'b0;
		else
			read_done <= pop_ack && !pop_req;
	end

	// Every FIFO pop ack belongs to exactly one reader port
	assert property (@(posedge clk) disable iff (!resetn)
		pop_ack |-> $onehot(rd_ack));

endmodule

/* verilog/ctrl_port.sv */
// Control port responder
// Four-phase req/ack front end for the state word. A write becomes a
// single-cycle strobe, a read returns a snapshot of the state word.
`timescale 1ns/1ns

module ctrl_port (
	input  logic                           clk,
	input  logic                           resetn,
	input  logic                           ctrl_req,
	input  logic                           ctrl_wr,
	input  logic [mailbox_pkg::WORD_W-1:0] ctrl_wdata,
	output logic                           ctrl_ack,
	output logic [mailbox_pkg::WORD_W-1:0] ctrl_rdata,
	output logic                           state_wr,
	output logic [mailbox_pkg::WORD_W-1:0] state_wdata,
	input  logic [mailbox_pkg::WORD_W-1:0] state_word
);

	logic accept;

	// New request, taken only while ack is low
	assign accept = ctrl_req && !ctrl_ack;

	// Write lands on the same edge that raises ack
	assign state_wr = accept && ctrl_wr;
	assign state_wdata = ctrl_wdata;

	// Ack itself is the handshake state
	always_ff @(posedge clk)
	begin
		if (!resetn)
			ctrl_ack <= 1'b0;
		else if (accept)
			ctrl_ack <= 1'b1;
		else if (ctrl_ack && !ctrl_req)
			ctrl_ack <= 1'b0;
	end

	// Snapshot stays put while ack is high
	always_ff @(posedge clk)
	begin
		if (accept && !ctrl_wr)
			ctrl_rdata <= state_word;
	end

	// Requester keeps req up until ack and raises no new req before ack falls
	assert property (@(posedge clk) disable iff (!resetn)
		ctrl_req && !ctrl_ack |=> ctrl_req);
	assert property (@(posedge clk) disable iff (!resetn)
		ctrl_ack && !ctrl_req |=> !ctrl_req);

endmodule

/* verilog/mailbox_pkg.sv */
// Shared mailbox constants
// Word and id widths, state word field positions, FIFO size and timer period
package mailbox_pkg;

	localparam int WORD_W = 32;
	localparam int OWNER_W = 8;
	localparam int NUM_READERS = 3;
	localparam int BUSY_W = 8;

	// Owner id that marks a free mailbox
	localparam logic [OWNER_W-1:0] NO_OWNER = 8'hFF;

	// State word layout
	localparam int OWNER_MSB = 31;
	localparam int OWNER_LSB = 24;
	localparam int TQUOTA_MSB = 23;
	localparam int TQUOTA_LSB = 16;
	localparam int RLIMIT_MSB = 7;
	localparam int RLIMIT_LSB = 0;

	// Timer period in clock cycles
	localparam int TICK_CYCLES = 16;
	localparam int TICK_W = $clog2(TICK_CYCLES);

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW = 2;

	// No owner, no quota, no limit
	localparam logic [WORD_W-1:0] RESET_STATE = {NO_OWNER, {(WORD_W-OWNER_W){1'b0}}};

endpackage
